//--- common/marmot_cfg.svh
`ifndef MARMOT_CFG_SVH
`define MARMOT_CFG_SVH

// --------------------------------------------------
// bus and word geometry
// --------------------------------------------------

// width of a wishbone or ram word
`define MARMOT_DATA_W 32

// --------------------------------------------------
// dtim bank layout
// --------------------------------------------------

// number of single-port macro banks
`define MARMOT_BANKS 4
// log2 of the bank count
`define MARMOT_BANK_W 2
// row address bits per bank, 512 words each
`define MARMOT_ROW_W 9

// address bit that selects the ram region when set,
// control register otherwise
`define MARMOT_RAM_SEL_BIT 20

`endif

//--- common/marmot_pkg.sv
`include "marmot_cfg.svh"

package marmot_pkg;

    // data word and its byte lanes
    typedef logic [`MARMOT_DATA_W-1:0] word_t;
    typedef logic [`MARMOT_DATA_W/8-1:0] mask_t;

    // dtim addressing
    typedef logic [`MARMOT_ROW_W-1:0] row_t;
    typedef logic [`MARMOT_BANK_W-1:0] bank_idx_t;

    // access being served by the wishbone slave
    typedef enum logic [2:0] {
        OP_NONE,
        OP_REG_RD,
        OP_REG_WR,
        OP_RAM_RD,
        OP_RAM_WR
    } wb_op_e;

endpackage

//--- verilog/wb_ctrl_slave.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module wb_ctrl_slave (
    input  logic                  clk,
    input  logic                  wb_rst_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_cyc_i,
    input  logic                  wbs_we_i,
    input  marmot_pkg::mask_t     wbs_sel_i,
    input  marmot_pkg::word_t     wbs_dat_i,
    input  logic [31:0]           wbs_adr_i,
    output logic                  wbs_ack_o,
    output marmot_pkg::word_t     wbs_dat_o,
    output marmot_pkg::word_t     ctrl_o,
    output logic                  ram_req_o,
    output logic                  ram_we_o,
    output marmot_pkg::bank_idx_t ram_bank_o,
    output marmot_pkg::row_t      ram_row_o,
    output marmot_pkg::word_t     ram_wdata_o,
    output marmot_pkg::mask_t     ram_mask_o,
    input  marmot_pkg::word_t     ram_rdata_i
);

    // row sits above the byte offset and bank above the row
    localparam int ROW_LSB  = 2;
    localparam int BANK_LSB = ROW_LSB + `MARMOT_ROW_W;
    localparam int LANES    = `MARMOT_DATA_W / 8;

    logic               wb_req;
    logic               wb_accept;
    logic               ack_q;
    marmot_pkg::wb_op_e op_d;
    marmot_pkg::wb_op_e op_q;
    marmot_pkg::word_t  ctrl_q;

    // --------------------------------------------------
    // request decode
    // --------------------------------------------------

    assign wb_req    = wbs_cyc_i && wbs_stb_i;
    // no new request while ack is out
    assign wb_accept = wb_req && !ack_q;

    always_comb begin
        op_d = marmot_pkg::OP_NONE;
        if (wb_accept) begin
            if (wbs_adr_i[`MARMOT_RAM_SEL_BIT]) begin
                op_d = wbs_we_i ? marmot_pkg::OP_RAM_WR : marmot_pkg::OP_RAM_RD;
            end else begin
                op_d = wbs_we_i ? marmot_pkg::OP_REG_WR : marmot_pkg::OP_REG_RD;
            end
        end
    end

    // --------------------------------------------------
    // logical ram port valid in the accept cycle
    // --------------------------------------------------

    assign ram_req_o   = (op_d == marmot_pkg::OP_RAM_RD) || (op_d == marmot_pkg::OP_RAM_WR);
    assign ram_we_o    = wbs_we_i;
    assign ram_bank_o  = wbs_adr_i[BANK_LSB +: `MARMOT_BANK_W];
    assign ram_row_o   = wbs_adr_i[ROW_LSB +: `MARMOT_ROW_W];
    assign ram_wdata_o = wbs_dat_i;
    assign ram_mask_o  = wbs_sel_i;

    // --------------------------------------------------
    // ack, op tracking and control register
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (wb_rst_i) begin
            ack_q  <= 1'b0;
            op_q   <= marmot_pkg::OP_NONE;
            ctrl_q <= '0;
        end else begin
            ack_q <= wb_accept;
            op_q  <= op_d;
            if (op_d == marmot_pkg::OP_REG_WR) begin
                // byte lanes follow sel
                for (int b = 0; b < LANES; b++) begin
                    if (wbs_sel_i[b]) begin
                        ctrl_q[b*8 +: 8] <= wbs_dat_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign wbs_ack_o = ack_q;
    assign ctrl_o    = ctrl_q;

    // ram read data arrives from the mux in the ack cycle
    assign wbs_dat_o = (op_q == marmot_pkg::OP_RAM_RD) ? ram_rdata_i : ctrl_q;

    // region and direction of a request decide the op
    req_known_a: assert property (
        @(posedge clk) disable iff (wb_rst_i)
        wb_req |-> !$isunknown({wbs_we_i, wbs_adr_i[`MARMOT_RAM_SEL_BIT]})
    ) else $error("wishbone request with unknown region or direction");

endmodule

//--- dtim/dtim_bank_decode.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module dtim_bank_decode (
    input  logic                     ram_req_i,
    input  logic                     ram_we_i,
    input  marmot_pkg::bank_idx_t    ram_bank_i,
    input  marmot_pkg::row_t         ram_row_i,
    input  marmot_pkg::word_t        ram_wdata_i,
    input  marmot_pkg::mask_t        ram_mask_i,
    output logic [`MARMOT_BANKS-1:0] bank_csb_o,
    output logic                     bank_web_o,
    output marmot_pkg::row_t         bank_row_o,
    output marmot_pkg::word_t        bank_wdata_o,
    output marmot_pkg::mask_t        bank_mask_o
);

    // --------------------------------------------------
    // chip selects, active low
    // --------------------------------------------------

    always_comb begin
        bank_csb_o = '1;
        if (ram_req_i) begin
            for (int i = 0; i < `MARMOT_BANKS; i++) begin
                if (ram_bank_i == marmot_pkg::bank_idx_t'(i)) begin
                    bank_csb_o[i] = 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------
    // shared macro buses
    // --------------------------------------------------

    // web low means write
    assign bank_web_o   = !ram_we_i;
    assign bank_row_o   = ram_row_i;
    assign bank_wdata_o = ram_wdata_i;
    // only the masked bytes change on a write
    assign bank_mask_o  = ram_mask_i;

    // a request must name a real bank and direction
    always_comb begin
        bank_known_a: assert #0 (!ram_req_i || !$isunknown({ram_we_i, ram_bank_i}))
            else $error("ram request with unknown bank index or direction");
    end

endmodule

//--- dtim/dtim_sram_bank.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module dtim_sram_bank (
    input  logic              clk,
    input  logic              csb_i,
    input  logic              web_i,
    input  marmot_pkg::row_t  row_i,
    input  marmot_pkg::word_t wdata_i,
    input  marmot_pkg::mask_t mask_i,
    output marmot_pkg::word_t rdata_o
);

    localparam int DEPTH = 1 << `MARMOT_ROW_W;
    localparam int LANES = `MARMOT_DATA_W / 8;

    // --------------------------------------------------
    // storage and read register
    // --------------------------------------------------

    marmot_pkg::word_t mem [DEPTH];
    marmot_pkg::word_t rdata_q;

    always_ff @(posedge clk) begin
        if (!csb_i) begin
            if (!web_i) begin
                // masked byte write
                for (int b = 0; b < LANES; b++) begin
                    if (mask_i[b]) begin
                        mem[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                // read data shows after this edge
                rdata_q <= mem[row_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- dtim/dtim_read_mux.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module dtim_read_mux (
    input  logic                  clk,
    input  logic                  wb_rst_i,
    input  logic                  rd_req_i,
    input  marmot_pkg::bank_idx_t rd_bank_i,
    input  marmot_pkg::word_t     bank_rdata_i [`MARMOT_BANKS],
    output marmot_pkg::word_t     rdata_o
);

    // bank that was read on the last request
    marmot_pkg::bank_idx_t rd_bank_q;

    always_ff @(posedge clk) begin
        if (wb_rst_i) begin
            rd_bank_q <= '0;
        end else if (rd_req_i) begin
            rd_bank_q <= rd_bank_i;
        end
    end

    // macro outputs are already registered, so select in the ack cycle
    assign rdata_o = bank_rdata_i[rd_bank_q];

endmodule

//--- verilog/marmot_top.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module marmot_top (
    input  logic              clk,
    input  logic              wb_rst_i,
    input  logic              wbs_stb_i,
    input  logic              wbs_cyc_i,
    input  logic              wbs_we_i,
    input  marmot_pkg::mask_t wbs_sel_i,
    input  marmot_pkg::word_t wbs_dat_i,
    input  logic [31:0]       wbs_adr_i,
    output logic              wbs_ack_o,
    output marmot_pkg::word_t wbs_dat_o,
    output marmot_pkg::word_t ctrl_o
);

    // logical ram port from the slave
    logic                  ram_req;
    logic                  ram_we;
    marmot_pkg::bank_idx_t ram_bank;
    marmot_pkg::row_t      ram_row;
    marmot_pkg::word_t     ram_wdata;
    marmot_pkg::mask_t     ram_mask;
    marmot_pkg::word_t     ram_rdata;

    // shared macro buses
    logic [`MARMOT_BANKS-1:0] bank_csb;
    logic                     bank_web;
    marmot_pkg::row_t         bank_row;
    marmot_pkg::word_t        bank_wdata;
    marmot_pkg::mask_t        bank_mask;
    marmot_pkg::word_t        bank_rdata [`MARMOT_BANKS];

    wb_ctrl_slave u_slave (
        .clk         (clk),
        .wb_rst_i    (wb_rst_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .ctrl_o      (ctrl_o),
        .ram_req_o   (ram_req),
        .ram_we_o    (ram_we),
        .ram_bank_o  (ram_bank),
        .ram_row_o   (ram_row),
        .ram_wdata_o (ram_wdata),
        .ram_mask_o  (ram_mask),
        .ram_rdata_i (ram_rdata)
    );

    dtim_bank_decode u_decode (
        .ram_req_i    (ram_req),
        .ram_we_i     (ram_we),
        .ram_bank_i   (ram_bank),
        .ram_row_i    (ram_row),
        .ram_wdata_i  (ram_wdata),
        .ram_mask_i   (ram_mask),
        .bank_csb_o   (bank_csb),
        .bank_web_o   (bank_web),
        .bank_row_o   (bank_row),
        .bank_wdata_o (bank_wdata),
        .bank_mask_o  (bank_mask)
    );

    // one macro per bank, all on the shared buses
    for (genvar g = 0; g < `MARMOT_BANKS; g++) begin : g_bank
        dtim_sram_bank u_bank (
            .clk     (clk),
            .csb_i   (bank_csb[g]),
            .web_i   (bank_web),
            .row_i   (bank_row),
            .wdata_i (bank_wdata),
            .mask_i  (bank_mask),
            .rdata_o (bank_rdata[g])
        );
    end

    dtim_read_mux u_read_mux (
        .clk          (clk),
        .wb_rst_i     (wb_rst_i),
        .rd_req_i     (ram_req && !ram_we),
        .rd_bank_i    (ram_bank),
        .bank_rdata_i (bank_rdata),
        .rdata_o      (ram_rdata)
    );

endmodule

//--- tb/marmot_tb_util.svh
`ifndef MARMOT_TB_UTIL_SVH
`define MARMOT_TB_UTIL_SVH

// --------------------------------------------------
// random numbers and reference model
// --------------------------------------------------

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// byte lanes with sel set take the new data
function automatic marmot_pkg::word_t merge_lanes(input marmot_pkg::word_t old_w,
                                                  input marmot_pkg::word_t new_w,
                                                  input marmot_pkg::mask_t sel);
    marmot_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < `MARMOT_DATA_W / 8; b++) begin
        if (sel[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
        end
    end
    return res;
endfunction

// bank in [12:11], row in [10:2], ram region on the select bit
function automatic logic [31:0] ram_addr(input marmot_pkg::bank_idx_t bank,
                                         input marmot_pkg::row_t row);
    logic [31:0] a;
    a = '0;
    a[`MARMOT_RAM_SEL_BIT] = 1'b1;
    a[12:11] = bank;
    a[10:2] = row;
    return a;
endfunction

function automatic int unsigned ram_key(input logic [31:0] adr);
    return {21'b0, adr[12:2]};
endfunction

function automatic bit ram_written(input logic [31:0] adr);
    return model_mem.exists(ram_key(adr));
endfunction

// pattern built from the whole word address
function automatic marmot_pkg::word_t fill_word(input logic [10:0] key);
    return {key, 5'h15, ~key, 5'h0a};
endfunction

// applies one access to the model and returns what a read must see
function automatic marmot_pkg::word_t ref_access(input logic we, input logic [31:0] adr,
                                                 input marmot_pkg::mask_t sel,
                                                 input marmot_pkg::word_t wdata);
    marmot_pkg::word_t old_w;
    if (!adr[`MARMOT_RAM_SEL_BIT]) begin
        if (we) begin
            model_reg = merge_lanes(model_reg, wdata, sel);
        end
        return model_reg;
    end
    old_w = ram_written(adr) ? model_mem[ram_key(adr)] : '0;
    if (we) begin
        model_mem[ram_key(adr)] = merge_lanes(old_w, wdata, sel);
    end
    return old_w;
endfunction

// --------------------------------------------------
// checks and bus access
// --------------------------------------------------

task automatic check_value(input marmot_pkg::word_t got, input marmot_pkg::word_t exp_w,
                           input string what);
    if (got !== exp_w) begin
        $display("[FAIL] %0t ns: %s got %08h, expected %08h", $time, what, got, exp_w);
        err_count++;
    end
endtask

// one wishbone access held until its ack
task automatic bus_access(input logic we, input logic [31:0] adr,
                          input marmot_pkg::mask_t sel, input marmot_pkg::word_t wdata);
    int waited;
    logic got_ack;
    exp_rd_q.push_back(!we);
    exp_val_q.push_back(ref_access(we, adr, sel, wdata));
    @(posedge clk);
    #1;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = adr;
    wbs_sel_i = sel;
    wbs_dat_i = wdata;
    // ack must wait for the next edge
    #1;
    check_value(wbs_ack_o, 1'b0, "ack in the request cycle");
    waited  = 0;
    got_ack = 1'b0;
    while (!got_ack && waited < ACK_TIMEOUT) begin
        @(posedge clk);
        #1;
        waited++;
        got_ack = wbs_ack_o;
    end
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    if (!got_ack) begin
        abort_run($sformatf("no ack from the DUT for the access to %08h", adr));
    end else begin
        check_value(waited, 1, "ack latency in cycles");
    end
endtask

`endif

//--- tb/marmot_tb.sv
`timescale 1ns/1ps

`include "marmot_cfg.svh"

module marmot_tb;

    localparam int          ACK_TIMEOUT   = 20;
    localparam int          RESET_CYCLES  = 16;
    localparam int          RAND_ACCESSES = 200;
    localparam logic [31:0] RAND_SEED     = 32'h88ae_c2e0;

    logic              clk;
    logic              wb_rst_i;
    logic              wbs_stb_i;
    logic              wbs_cyc_i;
    logic              wbs_we_i;
    marmot_pkg::mask_t wbs_sel_i;
    marmot_pkg::word_t wbs_dat_i;
    logic [31:0]       wbs_adr_i;
    logic              wbs_ack_o;
    marmot_pkg::word_t wbs_dat_o;
    marmot_pkg::word_t ctrl_o;

    // reference state and pending acks
    marmot_pkg::word_t model_reg;
    marmot_pkg::word_t model_mem [int unsigned];
    logic [31:0]       rng_state;
    logic              exp_rd_q [$];
    marmot_pkg::word_t exp_val_q [$];
    int                err_count;
    int                errs_at_start;
    int                tests_passed;
    int                tests_failed;
    marmot_pkg::row_t  test_rows [3] = '{9'd0, 9'd5, 9'd511};

    marmot_top dut_i (
        .clk       (clk),
        .wb_rst_i  (wb_rst_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .ctrl_o    (ctrl_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Test FAILED");
        $finish;
    endtask

    `include "marmot_tb_util.svh"

    task automatic end_test(input int num, input string name);
        // let the compare process see the last ack
        repeat (2) @(posedge clk);
        if (err_count == errs_at_start) begin
            $display("test %0d %s: pass", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, err_count - errs_at_start);
            tests_failed++;
        end
        errs_at_start = err_count;
    endtask

    // --------------------------------------------------
    // compare process, one entry per ack
    // --------------------------------------------------

    always @(posedge clk) begin : compare_acks
        logic              is_rd;
        marmot_pkg::word_t exp_w;
        #2;
        if (!wb_rst_i && wbs_ack_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("unexpected ack from the DUT with no request at %0t ns", $time);
                err_count++;
            end else begin
                is_rd = exp_rd_q.pop_front();
                exp_w = exp_val_q.pop_front();
                if (is_rd) begin
                    check_value(wbs_dat_o, exp_w, "read data at ack");
                end
            end
        end
    end

    initial begin
        logic [31:0]           r;
        logic [31:0]           d;
        logic [31:0]           a;
        marmot_pkg::mask_t     sel;
        marmot_pkg::mask_t     part_sel [8];
        marmot_pkg::bank_idx_t bank;
        marmot_pkg::row_t      row;
        clk = 1'b0;
        wb_rst_i  = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_dat_i = '0;
        wbs_adr_i = '0;
        model_reg = '0;
        rng_state = RAND_SEED;
        err_count = 0;
        errs_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        part_sel = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'h9, 4'h3, 4'hc};
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        wb_rst_i = 1'b0;

        // reset state, idle bus must stay quiet
        check_value(ctrl_o, '0, "ctrl_o after reset");
        repeat (8) @(posedge clk);
        bus_access(1'b0, 32'h0, 4'hf, 32'h0);
        end_test(1, "reset state");

        for (int i = 0; i < 12; i++) begin
            bus_access(1'b1, 32'h0, part_sel[i % 8] ^ {2'b0, i[3], 1'b0}, next_rand());
            check_value(ctrl_o, model_reg, "ctrl_o after register write");
            bus_access(1'b0, 32'h0, 4'hf, 32'h0);
        end
        end_test(2, "register byte lanes");

        // fill every bank, then overwrite bank 0 only
        for (int b = 0; b < `MARMOT_BANKS; b++) begin
            for (int i = 0; i < 3; i++) begin
                a = ram_addr(marmot_pkg::bank_idx_t'(b), test_rows[i]);
                bus_access(1'b1, a, 4'hf, fill_word(a[12:2]));
            end
        end
        for (int i = 0; i < 3; i++) begin
            a = ram_addr(2'd0, test_rows[i]);
            bus_access(1'b1, a, 4'hf, ~fill_word(a[12:2]));
        end
        for (int b = 0; b < `MARMOT_BANKS; b++) begin
            for (int i = 0; i < 3; i++) begin
                bus_access(1'b0, ram_addr(marmot_pkg::bank_idx_t'(b), test_rows[i]), 4'hf, 32'h0);
            end
        end
        end_test(3, "bank fill and isolation");

        for (int i = 0; i < 16; i++) begin
            a = ram_addr(marmot_pkg::bank_idx_t'(i % 4), test_rows[i % 3]);
            bus_access(1'b1, a, part_sel[i % 8], next_rand());
            bus_access(1'b0, a, 4'hf, 32'h0);
        end
        end_test(4, "partial ram writes");

        // random mix over 64 ram words and the register
        for (int n = 0; n < RAND_ACCESSES; n++) begin
            r = next_rand();
            d = next_rand();
            bank = r[3:2];
            row = {5'b0, r[7:4]};
            sel = r[11:8];
            a = ram_addr(bank, row);
            case (r[1:0])
                2'd0: bus_access(1'b0, {12'h000, r[19:0]}, sel, d);
                2'd1: bus_access(1'b1, {12'h000, r[19:0]}, sel, d);
                2'd2: begin
                    if (ram_written(a)) begin
                        bus_access(1'b0, a, sel, d);
                    end else begin
                        bus_access(1'b1, a, 4'hf, d);
                    end
                end
                default: bus_access(1'b1, a, ram_written(a) ? sel : 4'hf, d);
            endcase
        end
        end_test(5, "random access mix");

        if (exp_rd_q.size() != 0) begin
            $display("%0d accesses never saw their ack checked", exp_rd_q.size());
            err_count++;
        end
        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+common
+incdir+tb
common/marmot_pkg.sv
verilog/wb_ctrl_slave.sv
dtim/dtim_bank_decode.sv
dtim/dtim_sram_bank.sv
dtim/dtim_read_mux.sv
verilog/marmot_top.sv
tb/marmot_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the marmot testbench with verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -f all.f --top-module marmot_tb -o marmot_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/marmot_sim > sim.log 2>&1
cat sim.log

grep -qx "Test OK" sim.log && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
